// ==== rtg_pkg.sv ====
// Shared widths, burst and FIFO constants for the RTG display stream, referenced by scoped names
package rtg_pkg;

  ////////////////////////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W     = 26;              // SDRAM byte address width
  localparam int BASE_LSB   = 4;               // Base address kept from bit 4 up
  localparam int WORD_W     = 16;              // Pixel word and SDRAM data width
  localparam int MANGLE_BIT = 23;              // Bit flipped by the CPU mapping

  // Words per memory burst, one fill pulse each
  localparam int BURST_WORDS = 4;
  localparam int BCNT_W      = $clog2(BURST_WORDS); // Fill pulse counter width

  ////////////////////////////////////////////////////////////
  // Stream FIFO
  ////////////////////////////////////////////////////////////

  localparam int FIFO_DEPTH = 16;              // Words held between fetch and display
  localparam int FIFO_AW    = 4;               // Pointer width, wraps at depth
  localparam int CNT_W      = 5;               // Occupancy 0..FIFO_DEPTH

  ////////////////////////////////////////////////////////////
  // Pixel side
  ////////////////////////////////////////////////////////////

  localparam int COLOR_W = 8;                  // One output colour channel
  localparam int PCLK_W  = 4;                  // Clocks per pixel minus one

  // Field positions inside a 5-6-5 word
  localparam int R16_HI = 15;                  // Red top bit
  localparam int G16_HI = 10;                  // Green top bit, six bits wide

  // Field positions inside a 5-5-5 word
  localparam int R15_HI = 14;                  // Red top bit, bit 15 unused
  localparam int G15_HI = 9;                   // Green top bit, five bits wide

  // Blue sits in the low five bits in both modes
  localparam int B_HI   = 4;

endpackage

// ==== rtg_fetch.sv ====
// Burst fetcher for the RTG stream, reads pixel words from SDRAM and pushes them into the FIFO
module rtg_fetch
(
  input  logic                                          CLK_114,
  input  logic                                          rst_n_i,
  input  logic                                          restart_i,    // Vblank or RTG off
  input  logic [rtg_pkg::ADDR_W-rtg_pkg::BASE_LSB-1:0] base_addr_i,  // Frame start, 16-byte units
  input  logic [rtg_pkg::CNT_W-1:0]                     fifo_count_i, // Words already buffered
  input  logic                                          mem_fill_i,   // One pulse per returned word
  input  logic [rtg_pkg::WORD_W-1:0]                    mem_data_i,
  output logic                                          mem_req_o,    // Burst open
  output logic [rtg_pkg::ADDR_W-1:0]                    mem_addr_o,   // Mangled first-word address
  output logic                                          wr_en_o,      // FIFO push
  output logic [rtg_pkg::WORD_W-1:0]                    wr_data_o
);

  logic [rtg_pkg::ADDR_W-2:0]   word_addr;  // Word address, byte bit 0 implied zero
  logic [rtg_pkg::ADDR_W-2:0]   base_word;  // Base expanded to a word address
  logic [rtg_pkg::ADDR_W-1:0]   byte_addr;
  logic [rtg_pkg::BCNT_W-1:0]   fill_cnt;   // Fill pulses seen in this burst
  logic                         fill_ok;
  logic                         last_fill;
  logic                         room;

  assign base_word = {base_addr_i, {(rtg_pkg::BASE_LSB-1){1'b0}}};
  assign byte_addr = {word_addr, 1'b0};

  ////////////////////////////////////////////////////////////
  // Address mangling as seen by the CPU
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    mem_addr_o = byte_addr;
    // Bit 23 toggles whenever bit 22 or 21 is set
    mem_addr_o[rtg_pkg::MANGLE_BIT] = byte_addr[rtg_pkg::MANGLE_BIT] ^
      (byte_addr[rtg_pkg::MANGLE_BIT-1] | byte_addr[rtg_pkg::MANGLE_BIT-2]);
  end

  // Fill pulses outside an open burst or during restart are dropped
  assign fill_ok   = mem_fill_i & mem_req_o & ~restart_i;
  assign last_fill = fill_ok && (fill_cnt == rtg_pkg::BCNT_W'(rtg_pkg::BURST_WORDS-1));
  assign wr_en_o   = fill_ok;                 // Same-cycle push
  assign wr_data_o = mem_data_i;

  // A full burst still fits in the FIFO
  assign room = ({1'b0, fifo_count_i} + (rtg_pkg::CNT_W+1)'(rtg_pkg::BURST_WORDS))
                <= (rtg_pkg::CNT_W+1)'(rtg_pkg::FIFO_DEPTH);

  ////////////////////////////////////////////////////////////
  // Burst control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114 or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mem_req_o <= 1'b0;
      fill_cnt  <= '0;
      word_addr <= '0;
    end
    else if (restart_i)
    begin
      mem_req_o <= 1'b0;                      // Abandon any open burst
      fill_cnt  <= '0;
      word_addr <= base_word;                 // Back to frame start
    end
    else if (fill_ok)
    begin
      fill_cnt <= fill_cnt + 1'b1;            // Wraps to zero after the last word
      if (last_fill)
      begin
        mem_req_o <= 1'b0;
        word_addr <= word_addr + (rtg_pkg::ADDR_W-1)'(rtg_pkg::BURST_WORDS);
      end
    end
    else if (!mem_req_o && room)
    begin
      mem_req_o <= 1'b1;                      // Open next burst
    end
  end

endmodule

// ==== rtg_fifo.sv ====
// Show-ahead word FIFO between the burst fetcher and the pixel engine, reports its occupancy
module rtg_fifo
(
  input  logic                         CLK_114,
  input  logic                         rst_n_i,
  input  logic                         restart_i,  // Flush on stream restart
  input  logic                         wr_en_i,
  input  logic [rtg_pkg::WORD_W-1:0]   wr_data_i,
  input  logic                         rd_en_i,    // Pop the word on rd_data_o
  output logic [rtg_pkg::WORD_W-1:0]   rd_data_o,  // Head word, valid while not empty
  output logic                         empty_o,
  output logic [rtg_pkg::CNT_W-1:0]    count_o
);

  logic [rtg_pkg::WORD_W-1:0]  mem [rtg_pkg::FIFO_DEPTH];  // Word storage
  logic [rtg_pkg::FIFO_AW-1:0] wr_ptr;
  logic [rtg_pkg::FIFO_AW-1:0] rd_ptr;
  logic                        full;
  logic                        do_wr;
  logic                        do_rd;

  assign full    = (count_o == rtg_pkg::CNT_W'(rtg_pkg::FIFO_DEPTH));
  assign empty_o = (count_o == '0);
  assign do_wr   = wr_en_i & ~full & ~restart_i;   // Overflow guard
  assign do_rd   = rd_en_i & ~empty_o & ~restart_i;

  // Head of queue shown without a read
  assign rd_data_o = mem[rd_ptr];

  always_ff @(posedge CLK_114)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data_i;
  end

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114 or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end
    else if (restart_i)
    begin
      wr_ptr  <= '0;                             // Drop all buffered words
      rd_ptr  <= '0;
      count_o <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;                 // Pointer wraps at depth
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        count_o <= count_o + 1'b1;
      else if (do_rd && !do_wr)
        count_o <= count_o - 1'b1;               // Both at once keeps count
    end
  end

endmodule

// ==== rtg_pixel_out.sv ====
// RTG pixel engine, paces FIFO pops per pixel period and drives registered RGB with a strobe
module rtg_pixel_out
(
  input  logic                         CLK_114,
  input  logic                         rst_n_i,
  input  logic                         restart_i,      // Vblank or RTG off
  input  logic                         rtg_16bit_i,    // 1 for 5-6-5, 0 for 5-5-5
  input  logic [rtg_pkg::PCLK_W-1:0]   pixel_width_i,  // Clocks per pixel minus one
  input  logic                         hblank_i,
  input  logic [rtg_pkg::WORD_W-1:0]   rd_data_i,      // FIFO head word
  input  logic                         empty_i,
  output logic                         rd_en_o,        // Pop strobe
  output logic                         vga_pixel_o,    // One pulse per new pixel
  output logic [rtg_pkg::COLOR_W-1:0]  vga_r_o,
  output logic [rtg_pkg::COLOR_W-1:0]  vga_g_o,
  output logic [rtg_pkg::COLOR_W-1:0]  vga_b_o
);

  logic [rtg_pkg::PCLK_W-1:0]  pix_cnt;   // Pixel period counter
  logic                        blank;
  logic                        at_width;
  logic                        pop;
  logic [rtg_pkg::COLOR_W-1:0] dec_r;
  logic [rtg_pkg::COLOR_W-1:0] dec_g;
  logic [rtg_pkg::COLOR_W-1:0] dec_b;

  ////////////////////////////////////////////////////////////
  // Pixel pacing
  ////////////////////////////////////////////////////////////

  assign blank    = hblank_i | restart_i;
  assign at_width = (pix_cnt == pixel_width_i);
  assign pop      = ~blank & at_width & ~empty_i;  // Waits while FIFO is dry
  assign rd_en_o  = pop;

  always_ff @(posedge CLK_114 or negedge rst_n_i)
  begin
    if (!rst_n_i)
      pix_cnt <= '0;
    else if (blank || pop)
      pix_cnt <= '0;                             // New period
    else if (!at_width)
      pix_cnt <= pix_cnt + 1'b1;
    // At width with no data the counter holds
  end

  ////////////////////////////////////////////////////////////
  // Colour decode
  ////////////////////////////////////////////////////////////

  // Top bits repeat below each field's LSB to fill eight bits
  always_comb
  begin
    if (rtg_16bit_i)
    begin
      dec_r = {rd_data_i[rtg_pkg::R16_HI -: 5], rd_data_i[rtg_pkg::R16_HI -: 3]};
      dec_g = {rd_data_i[rtg_pkg::G16_HI -: 6], rd_data_i[rtg_pkg::G16_HI -: 2]};
    end
    else
    begin
      dec_r = {rd_data_i[rtg_pkg::R15_HI -: 5], rd_data_i[rtg_pkg::R15_HI -: 3]};
      dec_g = {rd_data_i[rtg_pkg::G15_HI -: 5], rd_data_i[rtg_pkg::G15_HI -: 3]};
    end
    dec_b = {rd_data_i[rtg_pkg::B_HI -: 5], rd_data_i[rtg_pkg::B_HI -: 3]};  // Same in both modes
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_114 or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      vga_pixel_o <= 1'b0;
      vga_r_o     <= '0;
      vga_g_o     <= '0;
      vga_b_o     <= '0;
    end
    else
    begin
      vga_pixel_o <= pop;                        // One cycle after the pop
      if (pop)
      begin
        vga_r_o <= dec_r;
        vga_g_o <= dec_g;
        vga_b_o <= dec_b;
      end
      else
      begin
        vga_r_o <= '0;                           // Black between pixels
        vga_g_o <= '0;
        vga_b_o <= '0;
      end
    end
  end

endmodule

// ==== rtg_video_top.sv ====
// RTG display stream top level, joins the burst fetcher, stream FIFO and pixel engine
module rtg_video_top
(
  input  logic                                          CLK_114,
  input  logic                                          rst_n_i,
  input  logic                                          rtg_ena_i,      // RTG screen on
  input  logic                                          rtg_16bit_i,    // 5-6-5 when high
  input  logic [rtg_pkg::PCLK_W-1:0]                    pixel_width_i,
  input  logic [rtg_pkg::ADDR_W-rtg_pkg::BASE_LSB-1:0] base_addr_i,
  input  logic                                          hblank_i,
  input  logic                                          vblank_i,
  input  logic                                          mem_fill_i,
  input  logic [rtg_pkg::WORD_W-1:0]                    mem_data_i,
  output logic                                          mem_req_o,
  output logic [rtg_pkg::ADDR_W-1:0]                    mem_addr_o,
  output logic                                          vga_pixel_o,
  output logic [rtg_pkg::COLOR_W-1:0]                   vga_r_o,
  output logic [rtg_pkg::COLOR_W-1:0]                   vga_g_o,
  output logic [rtg_pkg::COLOR_W-1:0]                   vga_b_o
);

  ////////////////////////////////////////////////////////////
  // Internal stream signals
  ////////////////////////////////////////////////////////////

  logic                         restart;     // Stream reset
  logic                         wr_en;       // Fetch to FIFO
  logic [rtg_pkg::WORD_W-1:0]   wr_data;
  logic [rtg_pkg::CNT_W-1:0]    fifo_count;  // FIFO back to fetch
  logic [rtg_pkg::WORD_W-1:0]   rd_data;     // FIFO to pixel engine
  logic                         empty;
  logic                         rd_en;

  // Each vblank, or RTG off, rewinds the stream to the base
  assign restart = vblank_i | ~rtg_ena_i;

  rtg_fetch rtg_fetch_inst
  (
    .CLK_114      (CLK_114),
    .rst_n_i      (rst_n_i),
    .restart_i    (restart),
    .base_addr_i  (base_addr_i),
    .fifo_count_i (fifo_count),
    .mem_fill_i   (mem_fill_i),
    .mem_data_i   (mem_data_i),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .wr_en_o      (wr_en),
    .wr_data_o    (wr_data)
  );

  rtg_fifo rtg_fifo_inst
  (
    .CLK_114   (CLK_114),
    .rst_n_i   (rst_n_i),
    .restart_i (restart),
    .wr_en_i   (wr_en),
    .wr_data_i (wr_data),
    .rd_en_i   (rd_en),
    .rd_data_o (rd_data),
    .empty_o   (empty),
    .count_o   (fifo_count)
  );

  rtg_pixel_out rtg_pixel_out_inst
  (
    .CLK_114       (CLK_114),
    .rst_n_i       (rst_n_i),
    .restart_i     (restart),
    .rtg_16bit_i   (rtg_16bit_i),
    .pixel_width_i (pixel_width_i),
    .hblank_i      (hblank_i),
    .rd_data_i     (rd_data),
    .empty_i       (empty),
    .rd_en_o       (rd_en),
    .vga_pixel_o   (vga_pixel_o),
    .vga_r_o       (vga_r_o),
    .vga_g_o       (vga_g_o),
    .vga_b_o       (vga_b_o)
  );

endmodule

// ==== rtg_video_asserts.sv ====
// Protocol assertions for the RTG stream that are bound into every rtg_video_top instance
module rtg_video_asserts
(
  input  logic                          CLK_114,
  input  logic                          rst_n_i,
  input  logic                          hblank_i,
  input  logic                          vblank_i,
  input  logic                          mem_req_i,    // Burst open
  input  logic [rtg_pkg::ADDR_W-1:0]    mem_addr_i,
  input  logic                          vga_pixel_i,  // Pixel strobe
  input  logic [rtg_pkg::COLOR_W-1:0]   vga_r_i,
  input  logic [rtg_pkg::COLOR_W-1:0]   vga_g_i,
  input  logic [rtg_pkg::COLOR_W-1:0]   vga_b_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;                            // Failed assertion count

  ////////////////////////////////////////////////////////////
  // Memory port and display checks
  ////////////////////////////////////////////////////////////

  // Address held until the burst closes or is abandoned
  addr_stable_a : assert property (@(posedge CLK_114) disable iff (!rst_n_i)
    mem_req_i |=> (!mem_req_i || $stable(mem_addr_i)))
  else
  begin
    $error("mem_addr_o moved while a burst was open");
    fail_cnt++;
  end

  // Registered strobe shows blanking one cycle later
  blank_quiet_a : assert property (@(posedge CLK_114) disable iff (!rst_n_i)
    (hblank_i || vblank_i) |=> !vga_pixel_i)
  else
  begin
    $error("vga_pixel_o pulsed during blanking");
    fail_cnt++;
  end

  rgb_black_a : assert property (@(posedge CLK_114) disable iff (!rst_n_i)
    !vga_pixel_i |-> (vga_r_i == '0 && vga_g_i == '0 && vga_b_i == '0))
  else
  begin
    $error("RGB not black without a pixel strobe");
    fail_cnt++;
  end

endmodule

bind rtg_video_top rtg_video_asserts rtg_video_asserts_inst
(
  .CLK_114     (CLK_114),
  .rst_n_i     (rst_n_i),
  .hblank_i    (hblank_i),
  .vblank_i    (vblank_i),
  .mem_req_i   (mem_req_o),
  .mem_addr_i  (mem_addr_o),
  .vga_pixel_i (vga_pixel_o),
  .vga_r_i     (vga_r_o),
  .vga_g_i     (vga_g_o),
  .vga_b_i     (vga_b_o)
);

// ==== tb_rtg_video.sv ====
// Testbench for rtg_video_top that runs the pattern file tests against a burst memory model
module tb_rtg_video;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 100;             // ns
  localparam int DRV_DLY     = 5;               // Drive point after the edge
  localparam int PIX_TIMEOUT = 400;             // Cycles allowed per pixel wait
  localparam int IDLE_CYCLES = 40;
  localparam int MEM_WORDS   = 16;              // Words at the head of the file
  localparam int TEST_BASE   = 16;              // First test line entry
  localparam int TEST_LEN    = 8;               // Entries per test line
  localparam int NUM_TESTS   = 3;

  logic                                          CLK_114 = 1'b0;
  logic                                          rst_n_i;
  logic                                          rtg_ena_i;
  logic                                          rtg_16bit_i;
  logic [rtg_pkg::PCLK_W-1:0]                    pixel_width_i;
  logic [rtg_pkg::ADDR_W-rtg_pkg::BASE_LSB-1:0] base_addr_i;
  logic                                          hblank_i;
  logic                                          vblank_i;
  logic                                          mem_fill_i;
  logic [rtg_pkg::WORD_W-1:0]                    mem_data_i;
  logic                                          mem_req_o;
  logic [rtg_pkg::ADDR_W-1:0]                    mem_addr_o;
  logic                                          vga_pixel_o;
  logic [rtg_pkg::COLOR_W-1:0]                   vga_r_o;
  logic [rtg_pkg::COLOR_W-1:0]                   vga_g_o;
  logic [rtg_pkg::COLOR_W-1:0]                   vga_b_o;

  logic [31:0]               pat [0:63];       // Memory words followed by test lines
  logic [rtg_pkg::ADDR_W-1:0] base_byte;       // Byte address of frame start
  integer                    seed = 32'h70ca_9a66;
  string                     test_name;
  int                        err_cnt;
  int                        test_cnt;
  int                        delay_max;        // Largest fill delay in cycles
  int                        burst_num;        // Bursts since last restart
  int                        word_base;
  int                        fill_k;
  int                        fill_wait;
  int                        addr_seen;
  bit                        busy;

  always #(CLK_PERIOD / 2) CLK_114 = ~CLK_114;

  rtg_video_top rtg_video_top_inst (.*);

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      err_cnt++;
    end
  endtask

  // Bit 23 toggles when bit 22 or 21 is set
  function automatic logic [rtg_pkg::ADDR_W-1:0] mangle_addr(input logic [rtg_pkg::ADDR_W-1:0] a);
    logic [rtg_pkg::ADDR_W-1:0] r;
    r = a;
    r[23] = a[23] ^ (a[22] | a[21]);
    return r;
  endfunction

  function automatic int pick_delay(input int max_wait);
    int r;
    r = 0;
    if (max_wait > 0)
      r = $unsigned($random(seed)) % (max_wait + 1);
    return r;
  endfunction

  task automatic step_cycle();
    @(posedge CLK_114);
    #DRV_DLY;                                  // Inputs change once outputs have settled
  endtask

  ////////////////////////////////////////////////////////////
  // Burst memory model
  ////////////////////////////////////////////////////////////

  always
  begin
    step_cycle();
    mem_fill_i = 1'b0;
    if (!mem_req_o)
      busy = 1'b0;                             // Burst done or abandoned
    else if (!busy)
    begin
      busy      = 1'b1;
      fill_k    = 0;
      fill_wait = pick_delay(delay_max);
      word_base = burst_num * rtg_pkg::BURST_WORDS;
      check_value({test_name, " addr"},
                  mangle_addr(base_byte + word_base * 2), mem_addr_o);
      burst_num++;
      addr_seen++;
    end
    if (busy && fill_k < rtg_pkg::BURST_WORDS)
    begin
      if (fill_wait == 0)
      begin
        mem_fill_i = 1'b1;
        mem_data_i = pat[(word_base + fill_k) % MEM_WORDS][15:0];
        fill_k++;
        fill_wait = pick_delay(delay_max);
      end
      else
        fill_wait--;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////////////////////////

  task automatic wait_pixel(output int waited, output bit seen);
    int i;
    seen   = 1'b0;
    waited = 0;
    for (i = 1; i <= PIX_TIMEOUT && !seen; i++)
    begin
      step_cycle();
      if (vga_pixel_o)
      begin
        seen   = 1'b1;
        waited = i;                            // Cycles since the previous strobe
      end
    end
    if (!seen)
    begin
      $display("no pixel strobe before timeout in test %s", test_name);
      err_cnt++;
    end
  endtask

  task automatic run_pattern_test(input int t);
    int  row;
    int  i;
    int  waited;
    int  errs_before;
    int  strobes;
    bit  seen;
    row         = TEST_BASE + t * TEST_LEN;
    errs_before = err_cnt;
    test_name   = $sformatf("pattern_%0d", t);
    vblank_i      = 1'b1;
    rtg_16bit_i   = pat[row][0];
    pixel_width_i = pat[row+1][rtg_pkg::PCLK_W-1:0];
    base_addr_i   = pat[row+2][rtg_pkg::ADDR_W-rtg_pkg::BASE_LSB-1:0];
    base_byte     = {base_addr_i, 4'h0};
    delay_max     = pat[row+3];
    step_cycle();
    step_cycle();
    burst_num = 0;                             // Fetcher is back at the base
    vblank_i  = 1'b0;
    for (i = 0; i < 4; i++)
    begin
      wait_pixel(waited, seen);
      if (seen)
      begin
        check_value(test_name, pat[row+4+i], {vga_r_o, vga_g_o, vga_b_o});
        if (i > 0 && delay_max == 0)
          check_value({test_name, " spacing"}, pixel_width_i + 1, waited);
      end
    end
    hblank_i = 1'b1;
    strobes  = 0;
    repeat (8)
    begin
      step_cycle();
      if (vga_pixel_o)
        strobes++;
    end
    check_value({test_name, " hblank"}, 0, strobes);
    hblank_i = 1'b0;
    vblank_i = 1'b1;                           // Mid-frame restart
    step_cycle();
    burst_num = 0;
    step_cycle();
    vblank_i = 1'b0;
    wait_pixel(waited, seen);
    if (seen)
      check_value({test_name, " restart"}, pat[row+4], {vga_r_o, vga_g_o, vga_b_o});
    test_cnt++;
    $display("test %s finished, %0d errors", test_name, err_cnt - errs_before);
  endtask

  task automatic run_disabled_test();
    int errs_before;
    int bad;
    errs_before = err_cnt;
    test_name   = "rtg_off";
    rtg_ena_i   = 1'b0;
    bad         = 0;
    repeat (IDLE_CYCLES)
    begin
      step_cycle();
      if (mem_req_o || vga_pixel_o || {vga_r_o, vga_g_o, vga_b_o} != '0)
        bad++;
    end
    check_value({test_name, " idle"}, 0, bad);
    test_cnt++;
    $display("test %s finished, %0d errors", test_name, err_cnt - errs_before);
  endtask

  initial
  begin
    rst_n_i       = 1'b0;
    rtg_ena_i     = 1'b0;
    rtg_16bit_i   = 1'b0;
    pixel_width_i = '0;
    base_addr_i   = '0;
    hblank_i      = 1'b0;
    vblank_i      = 1'b1;
    mem_fill_i    = 1'b0;
    mem_data_i    = '0;
    base_byte     = '0;
    test_name     = "reset";
    err_cnt       = 0;
    test_cnt      = 0;
    delay_max     = 0;
    burst_num     = 0;
    addr_seen     = 0;
    busy          = 1'b0;
    $readmemh("rtg_patterns.txt", pat);
    repeat (4) @(posedge CLK_114);
    #DRV_DLY;
    rst_n_i   = 1'b1;
    rtg_ena_i = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++)
      run_pattern_test(t);
    run_disabled_test();
    check_value("assertions", 0, rtg_video_top_inst.rtg_video_asserts_inst.fail_cnt);
    $display("tests %0d, bursts %0d, errors %0d", test_cnt, addr_seen, err_cnt);
    if (err_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== rtg_patterns.txt ====
// Entries 00..0F are memory words in address order from the base
// Test line: mode(1=565 0=555) width base delay_max rgb0 rgb1 rgb2 rgb3
@00
F800 07E0 001F 1234
0000 FFFF 8000 7FFF
4210 AAAA 5555 0F0F
F0F0 1111 2222 3333
@10
// 5-6-5 at byte 0x10, tight bursts for pixel spacing
1 2 000001 0 FF0000 00FF00 0000FF 1045A5
// 5-5-5 of the same words with random fill delay
0 3 000001 3 F70000 08FF00 0000FF 218CA5
// Byte 0x400000 has bit 22 set, requests show bit 23 flipped
1 4 040000 1 FF0000 00FF00 0000FF 1045A5

// ==== verilog.f ====
rtg_pkg.sv
rtg_fetch.sv
rtg_fifo.sv
rtg_pixel_out.sv
rtg_video_top.sv
rtg_video_asserts.sv
tb_rtg_video.sv
